// File: common/mont_ctrl_pkg.sv
package mont_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PRE_B,
        PRE_M,
        ADD_B,
        ADD_M,
        SUB_M,
        ADD_BACK,
        FINISH
    } ctrl_state_t;

    // Left adder operand
    typedef enum logic {
        LHS_ACC,
        LHS_DOUBLE
    } add_lhs_t;

    // Right adder operand
    typedef enum logic [1:0] {
        RHS_B,
        RHS_M,
        RHS_B_DIGIT,
        RHS_M_DIGIT
    } add_rhs_t;

endpackage

// File: common/mont_params_pkg.sv
package mont_params_pkg;

    // Operand and modulus width
    localparam int OPERAND_W = 256;

    // Accumulator carries four extra bits, top bit is the sign
    localparam int ACC_W = OPERAND_W + 4;

    // Width of the 3B and 3M multiples
    localparam int MULT_W = OPERAND_W + 2;

    // Radix-4 digit count and the counter that walks them
    localparam int DIGITS      = OPERAND_W / 2;
    localparam int DIGIT_CNT_W = 7;

    // Adder split into equal limbs
    localparam int LIMBS  = 4;
    localparam int LIMB_W = ACC_W / LIMBS;

    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [ACC_W-1:0]     acc_t;
    typedef logic [MULT_W-1:0]    mult_t;
    typedef logic [LIMB_W-1:0]    limb_t;

endpackage

// File: mont_adder/adder_limb.sv
`timescale 1ns/1ps

module adder_limb import mont_params_pkg::*; #(
    parameter int LIMB_IDX = 0
) (
    input  logic  clk,
    input  logic  resetn,
    input  logic  capture,
    input  logic  enable,
    input  logic  carry_in,
    input  limb_t lhs_slice,
    input  limb_t rhs_slice,
    output limb_t sum_slice,
    output logic  carry_out
);

    limb_t           lhs_q;
    limb_t           rhs_q;
    limb_t           sum_q;
    logic            carry_q;
    logic            inject_q;
    logic            cin;
    logic [LIMB_W:0] sum_full;

    always_ff @(posedge clk) begin
        if (capture) begin
            lhs_q <= lhs_slice;
            rhs_q <= rhs_slice;
        end
        if (enable) begin
            sum_q <= sum_full[LIMB_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            carry_q  <= 1'b0;
            inject_q <= 1'b0;
        end else begin
            if (capture) begin
                inject_q <= carry_in;
            end
            if (enable) begin
                carry_q <= sum_full[LIMB_W];
            end
        end
    end

    // Lowest limb keeps the subtract carry from capture time, others ripple
    assign cin = (LIMB_IDX == 0) ? inject_q : carry_in;

    assign sum_full  = {1'b0, lhs_q} + {1'b0, rhs_q} + {{LIMB_W{1'b0}}, cin};
    assign sum_slice = sum_q;
    assign carry_out = carry_q;

endmodule

// File: mont_adder/mont_adder.sv
`timescale 1ns/1ps

module mont_adder import mont_params_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic add_go,
    input  logic subtract,
    input  acc_t add_lhs,
    input  acc_t add_rhs,
    output acc_t sum,
    output logic add_done
);

    logic [LIMBS-1:0] stage;
    logic [LIMBS:0]   carry_chain;
    acc_t             rhs_eff;
    logic             done_q;

    // Two's complement subtract: inverted rhs plus one into limb 0
    assign rhs_eff        = subtract ? ~add_rhs : add_rhs;
    assign carry_chain[0] = subtract;

    // One-hot stage, limb i works in stage i
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage  <= '0;
            done_q <= 1'b0;
        end else begin
            stage  <= {stage[LIMBS-2:0], add_go};
            done_q <= stage[LIMBS-1];
        end
    end

    for (genvar i = 0; i < LIMBS; i++) begin : g_limb
        adder_limb #(
            .LIMB_IDX (i)
        ) i_limb (
            .clk       (clk),
            .resetn    (resetn),
            .capture   (add_go),
            .enable    (stage[i]),
            .carry_in  (carry_chain[i]),
            .lhs_slice (add_lhs[i*LIMB_W +: LIMB_W]),
            .rhs_slice (rhs_eff[i*LIMB_W +: LIMB_W]),
            .sum_slice (sum[i*LIMB_W +: LIMB_W]),
            .carry_out (carry_chain[i+1])
        );
    end

    assign add_done = done_q;

endmodule

// File: montgomery.f
common/mont_params_pkg.sv
common/mont_ctrl_pkg.sv
mont_adder/adder_limb.sv
mont_adder/mont_adder.sv
source/mont_accumulator.sv
source/mont_operand_select.sv
source/mont_controller.sv
source/montgomery.sv
tests/montgomery_checker.sv
tests/montgomery_tb.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module montgomery_tb -f montgomery.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vmontgomery_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: source/mont_accumulator.sv
`timescale 1ns/1ps

module mont_accumulator import mont_params_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     acc_clear,
    input  logic     acc_load,
    input  logic     acc_shift,
    input  acc_t     sum,
    output acc_t     acc,
    output logic     acc_sign,
    output operand_t result
);

    acc_t acc_q;
    acc_t sum_shifted;

    // Arithmetic shift, sign bit copied into the top two bits
    assign sum_shifted = {{2{sum[ACC_W-1]}}, sum[ACC_W-1:2]};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc_q <= '0;
        end else if (acc_clear) begin
            acc_q <= '0;
        end else if (acc_load) begin
            acc_q <= acc_shift ? sum_shifted : sum;
        end
    end

    assign acc      = acc_q;
    assign acc_sign = acc_q[ACC_W-1];
    assign result   = acc_q[OPERAND_W-1:0];

endmodule

// File: source/mont_controller.sv
`timescale 1ns/1ps

module mont_controller import mont_params_pkg::*, mont_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  logic     add_done,
    input  logic     acc_sign,
    output logic     add_go,
    output logic     subtract,
    output logic     load_b3,
    output logic     load_m3,
    output logic     shift_a,
    output logic     acc_clear,
    output logic     acc_load,
    output logic     acc_shift,
    output logic     operands_load,
    output logic     done,
    output add_lhs_t lhs_sel,
    output add_rhs_t rhs_sel
);

    ctrl_state_t            state;
    ctrl_state_t            state_next;
    logic                   issued;
    logic                   issued_next;
    logic [DIGIT_CNT_W-1:0] digit_cnt;
    logic [DIGIT_CNT_W-1:0] digit_cnt_next;
    logic                   last_digit;

    assign last_digit = (digit_cnt == DIGIT_CNT_W'(DIGITS - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= IDLE;
            issued    <= 1'b0;
            digit_cnt <= '0;
        end else begin
            state     <= state_next;
            issued    <= issued_next;
            digit_cnt <= digit_cnt_next;
        end
    end

    // Each working state: issue one addition, then wait for add_done
    always_comb begin
        state_next     = state;
        issued_next    = issued;
        digit_cnt_next = digit_cnt;
        add_go         = 1'b0;
        load_b3        = 1'b0;
        load_m3        = 1'b0;
        shift_a        = 1'b0;
        acc_clear      = 1'b0;
        acc_load       = 1'b0;
        acc_shift      = 1'b0;
        operands_load  = 1'b0;
        done           = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    operands_load  = 1'b1;
                    acc_clear      = 1'b1;
                    digit_cnt_next = '0;
                    state_next     = PRE_B;
                end
            end
            FINISH: begin
                done       = 1'b1;
                state_next = IDLE;
            end
            default: begin
                if (!issued) begin
                    // Reduction stops once the accumulator went negative
                    if (state == SUB_M && acc_sign) begin
                        state_next = ADD_BACK;
                    end else begin
                        add_go      = 1'b1;
                        issued_next = 1'b1;
                    end
                end else if (add_done) begin
                    issued_next = 1'b0;
                    case (state)
                        PRE_B: begin
                            load_b3    = 1'b1;
                            state_next = PRE_M;
                        end
                        PRE_M: begin
                            load_m3    = 1'b1;
                            state_next = ADD_B;
                        end
                        ADD_B: begin
                            acc_load   = 1'b1;
                            shift_a    = 1'b1;
                            state_next = ADD_M;
                        end
                        ADD_M: begin
                            acc_load       = 1'b1;
                            acc_shift      = 1'b1;
                            digit_cnt_next = digit_cnt + DIGIT_CNT_W'(1);
                            state_next     = last_digit ? SUB_M : ADD_B;
                        end
                        SUB_M: begin
                            acc_load = 1'b1;
                        end
                        ADD_BACK: begin
                            acc_load   = 1'b1;
                            state_next = FINISH;
                        end
                        default: begin
                            state_next = IDLE;
                        end
                    endcase
                end
            end
        endcase
    end

    // Operand routing per state
    always_comb begin
        subtract = (state == SUB_M);
        case (state)
            PRE_B:       begin lhs_sel = LHS_DOUBLE; rhs_sel = RHS_B;       end
            PRE_M:       begin lhs_sel = LHS_DOUBLE; rhs_sel = RHS_M;       end
            ADD_B:       begin lhs_sel = LHS_ACC;    rhs_sel = RHS_B_DIGIT; end
            ADD_M:       begin lhs_sel = LHS_ACC;    rhs_sel = RHS_M_DIGIT; end
            SUB_M:       begin lhs_sel = LHS_ACC;    rhs_sel = RHS_M;       end
            ADD_BACK:    begin lhs_sel = LHS_ACC;    rhs_sel = RHS_M;       end
            default:     begin lhs_sel = LHS_ACC;    rhs_sel = RHS_B;       end
        endcase
    end

endmodule

// File: source/mont_operand_select.sv
`timescale 1ns/1ps

module mont_operand_select import mont_params_pkg::*, mont_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     operands_load,
    input  logic     shift_a,
    input  logic     load_b3,
    input  logic     load_m3,
    input  operand_t a_in,
    input  operand_t b_in,
    input  operand_t m_in,
    input  acc_t     acc,
    input  acc_t     sum,
    input  add_lhs_t lhs_sel,
    input  add_rhs_t rhs_sel,
    output acc_t     add_lhs,
    output acc_t     add_rhs
);

    operand_t   a_q;
    operand_t   b_q;
    operand_t   m_q;
    mult_t      b3_q;
    mult_t      m3_q;
    operand_t   double_src;
    logic [1:0] q_digit;

    // 0, X, 2X or 3X for one radix-4 digit
    function automatic acc_t pick_multiple(input logic [1:0] digit, input operand_t x,
                                           input mult_t x3);
        acc_t res;
        case (digit)
            2'd1:    res = acc_t'(x);
            2'd2:    res = acc_t'({x, 1'b0});
            2'd3:    res = acc_t'(x3);
            default: res = '0;
        endcase
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_q <= '0;
            b_q <= '0;
            m_q <= '0;
        end else if (operands_load) begin
            a_q <= a_in;
            b_q <= b_in;
            m_q <= m_in;
        end else if (shift_a) begin
            // Next radix-4 digit of a into the low bits
            a_q <= a_q >> 2;
        end
    end

    // 3B and 3M come straight off the adder after precompute
    always_ff @(posedge clk) begin
        if (load_b3) begin
            b3_q <= sum[MULT_W-1:0];
        end
        if (load_m3) begin
            m3_q <= sum[MULT_W-1:0];
        end
    end

    // Quotient digit so that acc + q*M is divisible by 4
    // m = 3 mod 4 gives q = acc mod 4, m = 1 mod 4 gives q = -acc mod 4
    assign q_digit = m_q[1] ? acc[1:0] : 2'd0 - acc[1:0];

    assign double_src = (rhs_sel == RHS_M) ? m_q : b_q;

    assign add_lhs = (lhs_sel == LHS_DOUBLE) ? acc_t'({double_src, 1'b0}) : acc;

    always_comb begin
        case (rhs_sel)
            RHS_B:       add_rhs = acc_t'(b_q);
            RHS_M:       add_rhs = acc_t'(m_q);
            RHS_B_DIGIT: add_rhs = pick_multiple(a_q[1:0], b_q, b3_q);
            default:     add_rhs = pick_multiple(q_digit, m_q, m3_q);
        endcase
    end

endmodule

// File: source/montgomery.sv
`timescale 1ns/1ps

module montgomery import mont_params_pkg::*, mont_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  operand_t a_in,
    input  operand_t b_in,
    input  operand_t m_in,
    output operand_t result,
    output logic     done
);

    logic     add_go;
    logic     subtract;
    logic     add_done;
    logic     load_b3;
    logic     load_m3;
    logic     shift_a;
    logic     acc_clear;
    logic     acc_load;
    logic     acc_shift;
    logic     operands_load;
    logic     acc_sign;
    add_lhs_t lhs_sel;
    add_rhs_t rhs_sel;
    acc_t     add_lhs;
    acc_t     add_rhs;
    acc_t     sum;
    acc_t     acc;

    mont_controller i_controller (
        .clk           (clk),
        .resetn        (resetn),
        .start         (start),
        .add_done      (add_done),
        .acc_sign      (acc_sign),
        .add_go        (add_go),
        .subtract      (subtract),
        .load_b3       (load_b3),
        .load_m3       (load_m3),
        .shift_a       (shift_a),
        .acc_clear     (acc_clear),
        .acc_load      (acc_load),
        .acc_shift     (acc_shift),
        .operands_load (operands_load),
        .done          (done),
        .lhs_sel       (lhs_sel),
        .rhs_sel       (rhs_sel)
    );

    mont_operand_select i_operand_select (
        .clk           (clk),
        .resetn        (resetn),
        .operands_load (operands_load),
        .shift_a       (shift_a),
        .load_b3       (load_b3),
        .load_m3       (load_m3),
        .a_in          (a_in),
        .b_in          (b_in),
        .m_in          (m_in),
        .acc           (acc),
        .sum           (sum),
        .lhs_sel       (lhs_sel),
        .rhs_sel       (rhs_sel),
        .add_lhs       (add_lhs),
        .add_rhs       (add_rhs)
    );

    mont_adder i_adder (
        .clk      (clk),
        .resetn   (resetn),
        .add_go   (add_go),
        .subtract (subtract),
        .add_lhs  (add_lhs),
        .add_rhs  (add_rhs),
        .sum      (sum),
        .add_done (add_done)
    );

    mont_accumulator i_accumulator (
        .clk       (clk),
        .resetn    (resetn),
        .acc_clear (acc_clear),
        .acc_load  (acc_load),
        .acc_shift (acc_shift),
        .sum       (sum),
        .acc       (acc),
        .acc_sign  (acc_sign),
        .result    (result)
    );

endmodule

// File: tests/montgomery_checker.sv
`timescale 1ns/1ps

module montgomery_checker import mont_params_pkg::*; (
    input logic clk,
    input logic resetn,
    input logic add_go,
    input logic add_done,
    input logic done
);

    logic busy;
    int   latency_errors;
    int   overlap_errors;
    int   done_width_errors;
    int   reset_errors;
    int   failures;

    assign failures = latency_errors + overlap_errors + done_width_errors + reset_errors;

    // Adder counts as busy from add_go until its add_done
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
        end else if (add_go) begin
            busy <= 1'b1;
        end else if (add_done) begin
            busy <= 1'b0;
        end
    end

    adder_done_follows_go: assert property (@(posedge clk) disable iff (!resetn)
        add_done |-> $past(add_go, LIMBS + 1))
        else begin
            $error("add_done without add_go %0d cycles earlier", LIMBS + 1);
            latency_errors++;
        end

    adder_go_gets_done: assert property (@(posedge clk) disable iff (!resetn)
        $past(add_go, LIMBS + 1) |-> add_done)
        else begin
            $error("add_done missing %0d cycles after add_go", LIMBS + 1);
            latency_errors++;
        end

    adder_go_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        add_go |-> !busy)
        else begin
            $error("add_go raised while the adder is busy");
            overlap_errors++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            done_width_errors++;
        end

    done_low_in_reset: assert property (@(posedge clk)
        !resetn |=> !done)
        else begin
            $error("done high right after a reset cycle");
            reset_errors++;
        end

endmodule

bind montgomery montgomery_checker i_checker (
    .clk      (clk),
    .resetn   (resetn),
    .add_go   (add_go),
    .add_done (add_done),
    .done     (done)
);

// File: tests/montgomery_tb.sv
`timescale 1ns/1ps

module montgomery_tb import mont_params_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 50;
    localparam int NUM_OPS      = NUM_RANDOM + 10;
    // Worst case: precompute, two adds per digit, up to three SUB_M passes, ADD_BACK
    localparam int MAX_ADDS     = 2 + 2 * DIGITS + 3 + 1;
    // Issue cycle, LIMBS limb stages, done cycle
    localparam int MAX_LATENCY  = MAX_ADDS * (LIMBS + 2) + 4;
    localparam int TIMEOUT_NS   = NUM_OPS * MAX_LATENCY * CLK_PERIOD * 2;
    localparam int WIDE_W       = OPERAND_W + 5;

    typedef logic [WIDE_W-1:0] wide_t;

    logic     clk;
    logic     resetn;
    logic     start;
    operand_t a_in;
    operand_t b_in;
    operand_t m_in;
    operand_t result;
    logic     done;

    integer   seed = 32'ha8d369f6;
    operand_t expected_q[$];
    operand_t last_result;
    int       launched;
    int       done_count;
    int       check_count;
    int       error_count;
    int       tests_run;
    int       tests_failed;

    montgomery i_montgomery (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a_in   (a_in),
        .b_in   (b_in),
        .m_in   (m_in),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // a*b*4^-DIGITS mod m, one radix-4 digit of a per step
    function automatic operand_t mont_ref(input operand_t a, input operand_t b,
                                          input operand_t m);
        wide_t      acc;
        wide_t      wb;
        wide_t      wm;
        logic [1:0] q;
        acc = '0;
        wb  = wide_t'(b);
        wm  = wide_t'(m);
        for (int i = 0; i < DIGITS; i++) begin
            acc = acc + wide_t'(a[2*i +: 2]) * wb;
            // q = -acc / m mod 4, and m is its own inverse mod 4
            q   = (2'd0 - acc[1:0]) * m[1:0];
            acc = (acc + wide_t'(q) * wm) >> 2;
        end
        while (!acc[WIDE_W-1]) begin
            acc = acc - wm;
        end
        acc = acc + wm;
        return acc[OPERAND_W-1:0];
    endfunction

    task automatic check_value(input string name, input operand_t expected,
                               input operand_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic random_word(output operand_t v);
        for (int i = 0; i < OPERAND_W / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
    endtask

    // Odd modulus, a and b reduced below it
    task automatic random_operands(output operand_t a, output operand_t b, output operand_t m);
        random_word(m);
        m[0] = 1'b1;
        random_word(a);
        random_word(b);
        a = a % m;
        b = b % m;
    endtask

    task automatic launch_op(input operand_t a, input operand_t b, input operand_t m);
        @(negedge clk);
        a_in  = a;
        b_in  = b;
        m_in  = m;
        start = 1'b1;
        expected_q.push_back(mont_ref(a, b, m));
        launched++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_op(input operand_t a, input operand_t b, input operand_t m);
        launch_op(a, b, m);
        wait (done_count == launched);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Every done pulse retires the oldest pending operation
    initial begin : compare_results
        operand_t exp_val;
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                done_count++;
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected done pulse at %0t ns with no operation pending", $time);
                end else begin
                    exp_val = expected_q.pop_front();
                    check_value("result", exp_val, result);
                    last_result = exp_val;
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: run did not complete within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        operand_t op_a;
        operand_t op_b;
        operand_t op_m;
        int       errs;
        int       target;
        int       total_errors;
        resetn = 1'b0;
        start  = 1'b0;
        a_in   = '0;
        b_in   = '0;
        m_in   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;

        // Quiet outputs before the first start
        errs = error_count;
        repeat (10) begin
            @(negedge clk);
            check_value("done", '0, operand_t'(done));
            check_value("result", '0, result);
        end
        finish_test("after reset", errs);

        errs = error_count;
        random_operands(op_a, op_b, op_m);
        run_op('0, op_b, op_m);
        finish_test("zero operand", errs);

        errs = error_count;
        random_operands(op_a, op_b, op_m);
        run_op(operand_t'(1), operand_t'(1), op_m);
        finish_test("unit operands", errs);

        errs = error_count;
        random_operands(op_a, op_b, op_m);
        op_m[1:0] = 2'b01;
        run_op(op_a % op_m, op_b % op_m, op_m);
        finish_test("m mod 4 is 1", errs);

        errs = error_count;
        random_operands(op_a, op_b, op_m);
        op_m[1:0] = 2'b11;
        run_op(op_a % op_m, op_b % op_m, op_m);
        finish_test("m mod 4 is 3", errs);

        errs = error_count;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_operands(op_a, op_b, op_m);
            run_op(op_a, op_b, op_m);
        end
        finish_test("random operands", errs);

        // Second start arrives mid-operation with other inputs
        errs = error_count;
        random_operands(op_a, op_b, op_m);
        launch_op(op_a, op_b, op_m);
        target = launched;
        repeat (200) @(negedge clk);
        random_operands(op_a, op_b, op_m);
        a_in  = op_a;
        b_in  = op_b;
        m_in  = op_m;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait (done_count == target);
        // Long enough for a wrongly accepted operation to finish
        repeat (MAX_LATENCY) @(negedge clk);
        check_value("done count", operand_t'(target), operand_t'(done_count));
        finish_test("start while busy", errs);

        errs = error_count;
        random_operands(op_a, op_b, op_m);
        run_op(op_a, op_b, op_m);
        repeat (20) begin
            @(negedge clk);
            check_value("result", last_result, result);
        end
        for (int i = 0; i < 3; i++) begin
            random_operands(op_a, op_b, op_m);
            run_op(op_a, op_b, op_m);
        end
        // No extra done after the last operation
        repeat (MAX_LATENCY) @(negedge clk);
        check_value("done count", operand_t'(launched), operand_t'(done_count));
        finish_test("hold and back to back", errs);

        total_errors = error_count + i_montgomery.i_checker.failures;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, check_count, error_count,
                 i_montgomery.i_checker.failures);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
